/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  reg_t;
    typedef logic [25:0] jindex_t;             // J-type word index

    // Major opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;

    // SPECIAL funct codes
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_JALR = 6'h09;

    localparam reg_t REG_RA = 5'd31;           // Link register

    // Field positions in the instruction word
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RD_LSB     = 11;
    localparam int FUNCT_LSB  = 0;

endpackage

`default_nettype wire

/* hdl/bpu_pkg.sv */
`default_nettype none

package bpu_pkg;

    typedef logic [31:0] addr_t;

    localparam int RAS_DEPTH = 16;             // Default stack depth
    localparam int OVF_BITS  = 16;             // Overflow counter width

    typedef logic [OVF_BITS-1:0] ovf_cnt_t;

    // Sequential increments of the fetch PC
    localparam addr_t PC_STEP = 32'd4;
    localparam addr_t PC_LINK = 32'd8;         // Skip the delay slot

    // Classification from predecode to the next-PC select
    typedef enum logic [1:0] {
        KIND_OTHER = 2'd0,
        KIND_CALL  = 2'd1,
        KIND_RET   = 2'd2,
        KIND_JUMP  = 2'd3
    } br_kind_t;

endpackage

`default_nettype wire

/* hdl/ras_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module ras_ram #(
    parameter int ADDR_BITS = 4
) (
    input  wire logic                  clk,
    input  wire logic                  we,
    input  wire logic [ADDR_BITS-1:0]  addr,
    input  wire bpu_pkg::addr_t        wdata,
    output bpu_pkg::addr_t             rdata
);

    localparam int WORDS = 2 ** ADDR_BITS;

    bpu_pkg::addr_t mem [WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Zero read latency
    assign rdata = mem[addr];

endmodule

`default_nettype wire

/* hdl/ras.sv */
`timescale 1ns/10ps
`default_nettype none

module ras #(
    parameter int DEPTH = bpu_pkg::RAS_DEPTH
) (
    input  wire logic           clk,
    input  wire logic           resetn,
    input  wire logic           push,
    input  wire logic           pop,
    input  wire bpu_pkg::addr_t ret_pc_push,
    output bpu_pkg::addr_t      ret_pc_pop,
    output logic                fail,
    output logic                underrun,
    output logic                saturated
);

    localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [ADDR_BITS-1:0] ptr_t;

    localparam ptr_t TOP_MAX = ptr_t'(DEPTH - 1);

    // top stays 0 for both one entry and no entry, empty tells them apart
    ptr_t top, top_nxt, ram_addr;
    logic empty, empty_nxt;
    logic overflow, overflow_nxt;
    logic underrun_nxt, saturated_nxt;
    bpu_pkg::ovf_cnt_t ovf_cnt, ovf_cnt_nxt;
    logic full;
    logic cnt_zero;
    logic cnt_max;
    logic ram_we;

    assign full     = (top == TOP_MAX);
    assign cnt_zero = (ovf_cnt == '0);
    assign cnt_max  = &ovf_cnt;
    assign fail     = empty | overflow;

    always_comb begin
        empty_nxt = empty;
        if (push) begin
            empty_nxt = 1'b0;
        end else if (pop && top == '0) begin
            empty_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            empty <= 1'b1;
        end else begin
            empty <= empty_nxt;
        end
    end

    always_comb begin
        top_nxt = top;
        if (push && !full && !empty) begin
            top_nxt = top + ptr_t'(1);
        end else if (pop && top != '0 && !overflow) begin
            top_nxt = top - ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            top <= '0;
        end else begin
            top <= top_nxt;
        end
    end

    // Clears one edge after the counter has drained
    always_comb begin
        overflow_nxt = overflow;
        if (push && full) begin
            overflow_nxt = 1'b1;
        end else if (cnt_zero) begin
            overflow_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            overflow <= 1'b0;
        end else begin
            overflow <= overflow_nxt;
        end
    end

    always_comb begin
        ovf_cnt_nxt = ovf_cnt;
        if (push && full) begin
            if (!cnt_max) begin
                ovf_cnt_nxt = ovf_cnt + bpu_pkg::ovf_cnt_t'(1);  // Holds at max
            end
        end else if (pop && !cnt_zero) begin
            ovf_cnt_nxt = ovf_cnt - bpu_pkg::ovf_cnt_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ovf_cnt <= '0;
        end else begin
            ovf_cnt <= ovf_cnt_nxt;
        end
    end

    assign underrun_nxt  = underrun | (pop & empty);
    assign saturated_nxt = saturated | (push & full & cnt_max);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            underrun  <= 1'b0;
            saturated <= 1'b0;
        end else begin
            underrun  <= underrun_nxt;
            saturated <= saturated_nxt;
        end
    end

    assign ram_addr = push ? top_nxt : top;
    assign ram_we   = push & ~full;        // Overflowing pushes are dropped

    ras_ram #(
        .ADDR_BITS(ADDR_BITS)
    ) u_ram (
        .clk  (clk),
        .we   (ram_we),
        .addr (ram_addr),
        .wdata(ret_pc_push),
        .rdata(ret_pc_pop)
    );

endmodule

`default_nettype wire

/* hdl/branch_predecode.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_predecode (
    input  wire bpu_pkg::addr_t  pc,
    input  wire isa_pkg::instr_t instr,
    output bpu_pkg::br_kind_t    kind,
    output bpu_pkg::addr_t       target,
    output bpu_pkg::addr_t       link_pc
);

    isa_pkg::opcode_t opcode;
    isa_pkg::funct_t  funct;
    isa_pkg::reg_t    rs;
    isa_pkg::reg_t    rd;
    isa_pkg::jindex_t jindex;
    bpu_pkg::addr_t   pc_plus4;
    bpu_pkg::addr_t   j_target;
    logic             is_special;
    logic             is_jalr;

    assign opcode = instr[isa_pkg::OPCODE_LSB +: 6];
    assign funct  = instr[isa_pkg::FUNCT_LSB +: 6];
    assign rs     = instr[isa_pkg::RS_LSB +: 5];
    assign rd     = instr[isa_pkg::RD_LSB +: 5];
    assign jindex = instr[25:0];

    assign pc_plus4 = pc + bpu_pkg::PC_STEP;
    assign link_pc  = pc + bpu_pkg::PC_LINK;   // Return lands after the delay slot

    // Region of the delay slot, not of the jump itself
    assign j_target = {pc_plus4[31:28], jindex, 2'b00};

    assign is_special = (opcode == isa_pkg::OP_SPECIAL);
    assign is_jalr    = is_special && funct == isa_pkg::FN_JALR && rd == isa_pkg::REG_RA;

    always_comb begin
        kind = bpu_pkg::KIND_OTHER;
        if (opcode == isa_pkg::OP_JAL || is_jalr) begin
            kind = bpu_pkg::KIND_CALL;
        end else if (is_special && funct == isa_pkg::FN_JR && rs == isa_pkg::REG_RA) begin
            kind = bpu_pkg::KIND_RET;
        end else if (opcode == isa_pkg::OP_J) begin
            kind = bpu_pkg::KIND_JUMP;
        end
    end

    // No static target for jalr
    assign target = is_jalr ? link_pc : j_target;

endmodule

`default_nettype wire

/* hdl/ret_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module ret_predictor (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            fetch_valid,
    input  wire bpu_pkg::addr_t  fetch_pc,
    input  wire isa_pkg::instr_t fetch_instr,
    output bpu_pkg::addr_t       pred_pc,
    output logic                 ras_fail,
    output logic                 ras_underrun,
    output logic                 ras_saturated
);

    bpu_pkg::br_kind_t kind;
    bpu_pkg::addr_t    target;
    bpu_pkg::addr_t    link_pc;
    bpu_pkg::addr_t    ras_top_pc;
    logic              push;
    logic              pop;

    branch_predecode u_predecode (
        .pc     (fetch_pc),
        .instr  (fetch_instr),
        .kind   (kind),
        .target (target),
        .link_pc(link_pc)
    );

    assign push = fetch_valid && kind == bpu_pkg::KIND_CALL;
    assign pop  = fetch_valid && kind == bpu_pkg::KIND_RET;

    ras #(
        .DEPTH(bpu_pkg::RAS_DEPTH)
    ) u_ras (
        .clk        (clk),
        .resetn     (resetn),
        .push       (push),
        .pop        (pop),
        .ret_pc_push(link_pc),
        .ret_pc_pop (ras_top_pc),
        .fail       (ras_fail),
        .underrun   (ras_underrun),
        .saturated  (ras_saturated)
    );

    always_comb begin
        unique case (kind)
            bpu_pkg::KIND_RET:   pred_pc = ras_fail ? link_pc : ras_top_pc;  // Fall through
            bpu_pkg::KIND_CALL,
            bpu_pkg::KIND_JUMP:  pred_pc = target;
            default:             pred_pc = fetch_pc + bpu_pkg::PC_STEP;
        endcase
    end

endmodule

`default_nettype wire

/* sim/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released shortly after an edge, like the other inputs
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/ret_predictor_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module ret_predictor_sva #(
    parameter int PTR_BITS = 4
) (
    input wire logic                clk,
    input wire logic                resetn,
    input wire logic                push,
    input wire logic                pop,
    input wire logic [PTR_BITS-1:0] top,
    input wire logic                overflow,
    input wire logic                underrun,
    input wire logic                saturated
);

    // Stack pointer is frozen while overflowed pushes are outstanding
    a_top_frozen: assert property (@(posedge clk) disable iff (!resetn)
        overflow |=> $stable(top))
        else $error("top changed while overflow was set");

    a_no_push_pop: assert property (@(posedge clk) disable iff (!resetn)
        !(push && pop))
        else $error("push and pop asserted together");

    a_underrun_sticky: assert property (@(posedge clk) disable iff (!resetn)
        underrun |=> underrun)
        else $error("underrun flag dropped");

    a_saturated_sticky: assert property (@(posedge clk) disable iff (!resetn)
        saturated |=> saturated)
        else $error("saturated flag dropped");

endmodule

bind ras ret_predictor_sva #(
    .PTR_BITS(ADDR_BITS)
) u_sva (
    .clk      (clk),
    .resetn   (resetn),
    .push     (push),
    .pop      (pop),
    .top      (top),
    .overflow (overflow),
    .underrun (underrun),
    .saturated(saturated)
);

`default_nettype wire

/* sim/tb_ret_predictor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ret_predictor;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = CLK_PERIOD - DRIVE_DELAY - 1;  // Just before the next edge

    logic            clk;
    logic            resetn;
    logic            fetch_valid;
    bpu_pkg::addr_t  fetch_pc;
    isa_pkg::instr_t fetch_instr;
    bpu_pkg::addr_t  pred_pc;
    logic            ras_fail;
    logic            ras_underrun;
    logic            ras_saturated;

    string           case_name[$];
    bit              case_gap[$];
    bit              case_valid[$];
    bpu_pkg::addr_t  case_pc[$];
    isa_pkg::instr_t case_instr[$];
    bpu_pkg::addr_t  exp_pred[$];
    bit              exp_fail[$];
    bit              exp_underrun[$];
    logic            cases_loaded = 1'b0;
    logic [15:0]     lfsr_state = 16'd57383;

    tb_clkgen #(
        .PERIOD      (CLK_PERIOD),
        .RESET_CYCLES(2)
    ) u_clkgen (
        .clk   (clk),
        .resetn(resetn)
    );

    ret_predictor i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_instr  (fetch_instr),
        .pred_pc      (pred_pc),
        .ras_fail     (ras_fail),
        .ras_underrun (ras_underrun),
        .ras_saturated(ras_saturated)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_idle_cycles(output int cycles);
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b] = lfsr_state[0];
        end
        cycles = int'(bits);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: %s expected %h, actual %h", test, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          fields;
        string       line;
        string       name;
        int          gap;
        int          valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] pred;
        int          fail;
        int          urun;
        fd = $fopen("sim/ret_predictor_cases.txt", "r");
        if (fd == 0) begin
            $display("Test FAILED");
            $fatal(1, "Cannot open sim/ret_predictor_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%s %d %d %h %h %h %d %d",
                             name, gap, valid, pc, instr, pred, fail, urun);
            if (fields == 8) begin
                case_name.push_back(name);
                case_gap.push_back(gap != 0);
                case_valid.push_back(valid != 0);
                case_pc.push_back(pc);
                case_instr.push_back(instr);
                exp_pred.push_back(pred);
                exp_fail.push_back(fail != 0);
                exp_underrun.push_back(urun != 0);
            end else if (fields > 0 && name[0] != "#") begin
                $display("Test FAILED");
                $fatal(1, "Malformed line in the cases file: %s", line);
            end
        end
        $fclose(fd);
        if (case_name.size() == 0) begin
            $display("Test FAILED");
            $fatal(1, "The cases file holds no cases");
        end
    endtask

    initial begin : stimulus
        int idle;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_instr = '0;
        load_cases();
        cases_loaded = 1'b1;
        wait (resetn === 1'b1);
        for (int i = 0; i < case_name.size(); i++) begin
            if (case_gap[i]) begin
                draw_idle_cycles(idle);
                repeat (idle) begin
                    @(posedge clk);
                    #DRIVE_DELAY;
                    fetch_valid = 1'b0;
                    fetch_instr = '0;
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
            fetch_valid = case_valid[i];
            fetch_pc    = case_pc[i];
            fetch_instr = case_instr[i];
            #SAMPLE_DELAY;
            check_value(case_name[i], "pred_pc", exp_pred[i], pred_pc);
            check_value(case_name[i], "ras_fail", 32'(exp_fail[i]), 32'(ras_fail));
            check_value(case_name[i], "ras_underrun", 32'(exp_underrun[i]), 32'(ras_underrun));
            check_value(case_name[i], "ras_saturated", 32'd0, 32'(ras_saturated));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        fetch_valid = 1'b0;
        $display("Test OK");
        $finish;
    end

    // At most 3 idle cycles plus the fetch per case
    initial begin : watchdog
        int limit;
        wait (cases_loaded);
        limit = 4 * case_name.size() + 20;
        repeat (limit) @(posedge clk);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired after %0d cycles, the run did not finish", limit);
    end

endmodule

`default_nettype wire

/* sim/ret_predictor_cases.txt */
# name gap valid fetch_pc fetch_instr pred_pc ras_fail ras_underrun (hex for pc, instr, pred)
# gap 0 means no idle cycles before the fetch; valid 0 drives fetch_valid low
ret_empty      1 1 00400000 03e00008 00400008 1 0
nop_after_ret  1 1 00400004 00000000 00400008 1 1
call_a         1 1 00400100 0c100400 00401000 1 1
call_b         1 1 00401010 0c100800 00402000 0 1
call_c         1 1 00402020 0c100c00 00403000 0 1
ret_c          1 1 00403004 03e00008 00402028 0 1
ret_b          1 1 00402030 03e00008 00401018 0 1
ret_a          1 1 00401020 03e00008 00400108 0 1
call_d         1 1 00400200 0c101000 00404000 1 1
add_op         1 1 00404000 01095020 00404004 0 1
lw_op          1 1 00404004 8fbf0010 00404008 0 1
j_fwd          1 1 00404008 08101040 00404100 0 1
ret_d          1 1 00404100 03e00008 00400208 0 1
j_region       1 1 1ffffffc 08000040 20000100 1 1
ovf_call_00    1 1 00500000 0c180000 00600000 1 1
ovf_call_01    1 1 00500100 0c180000 00600000 0 1
ovf_call_02    1 1 00500200 0c180000 00600000 0 1
ovf_call_03    1 1 00500300 0c180000 00600000 0 1
ovf_call_04    1 1 00500400 0c180000 00600000 0 1
ovf_call_05    1 1 00500500 0c180000 00600000 0 1
ovf_call_06    1 1 00500600 0c180000 00600000 0 1
ovf_call_07    1 1 00500700 0c180000 00600000 0 1
ovf_call_08    1 1 00500800 0c180000 00600000 0 1
ovf_call_09    1 1 00500900 0c180000 00600000 0 1
ovf_call_10    1 1 00500a00 0c180000 00600000 0 1
ovf_call_11    1 1 00500b00 0c180000 00600000 0 1
ovf_call_12    1 1 00500c00 0c180000 00600000 0 1
ovf_call_13    1 1 00500d00 0c180000 00600000 0 1
ovf_call_14    1 1 00500e00 0c180000 00600000 0 1
ovf_call_15    1 1 00500f00 0c180000 00600000 0 1
ovf_call_16    1 1 00501000 0c180000 00600000 0 1
ovf_call_17    1 1 00501100 0c180000 00600000 1 1
ovf_ret_00     1 1 00600000 03e00008 00600008 1 1
ovf_ret_01     1 1 00600010 03e00008 00600018 1 1
ovf_drain      0 1 00600020 00000000 00600024 1 1
ovf_ret_02     1 1 00600030 03e00008 00500f08 0 1
ovf_ret_03     1 1 00600040 03e00008 00500e08 0 1
ovf_ret_04     1 1 00600050 03e00008 00500d08 0 1
ovf_ret_05     1 1 00600060 03e00008 00500c08 0 1
ovf_ret_06     1 1 00600070 03e00008 00500b08 0 1
ovf_ret_07     1 1 00600080 03e00008 00500a08 0 1
ovf_ret_08     1 1 00600090 03e00008 00500908 0 1
ovf_ret_09     1 1 006000a0 03e00008 00500808 0 1
ovf_ret_10     1 1 006000b0 03e00008 00500708 0 1
ovf_ret_11     1 1 006000c0 03e00008 00500608 0 1
ovf_ret_12     1 1 006000d0 03e00008 00500508 0 1
ovf_ret_13     1 1 006000e0 03e00008 00500408 0 1
ovf_ret_14     1 1 006000f0 03e00008 00500308 0 1
ovf_ret_15     1 1 00600100 03e00008 00500208 0 1
ovf_ret_16     1 1 00600110 03e00008 00500108 0 1
ovf_ret_17     1 1 00600120 03e00008 00500008 0 1
call_e         1 1 00700000 0c1c0400 00701000 1 1
call_nv        1 0 00710000 0c1c8000 00720000 0 1
ret_nv         1 0 00701000 03e00008 00700008 0 1
ret_e          1 1 00701004 03e00008 00700008 0 1
empty_chk      1 1 00700010 00000000 00700014 1 1
jalr_call      1 1 00800000 0320f809 00800008 1 1
ret_jalr       1 1 00900000 03e00008 00800008 0 1
jalr_nolink    1 1 00900004 03204009 00900008 1 1

/* files.f */
hdl/isa_pkg.sv
hdl/bpu_pkg.sv
hdl/ras_ram.sv
hdl/ras.sv
hdl/branch_predecode.sv
hdl/ret_predictor.sv
sim/tb_clkgen.sv
sim/ret_predictor_sva.sv
sim/tb_ret_predictor.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the return predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ret_predictor \
    -f files.f \
    -o tb_ret_predictor

./obj_dir/tb_ret_predictor
